// ==== icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry

// associativity
`define ICACHE_WAYS 4

// sets per way
`define ICACHE_SETS 128

// words in one line, also the burst length
`define ICACHE_LINE_WORDS 8

// bus widths

// byte address
`define ICACHE_ADDR_W 32

// one instruction word
`define ICACHE_DATA_W 32

`endif

// ==== icache_addr_pkg.sv ====
`default_nettype none

`include "icache_settings.svh"

package icache_addr_pkg;

    localparam int INDEX_W = $clog2(`ICACHE_SETS);
    localparam int WORD_SEL_W = $clog2(`ICACHE_LINE_WORDS);
    localparam int BYTE_W = $clog2(`ICACHE_DATA_W / 8);
    localparam int TAG_W = `ICACHE_ADDR_W - INDEX_W - WORD_SEL_W - BYTE_W;
    localparam int WAY_W = $clog2(`ICACHE_WAYS);

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [WAY_W-1:0] way_t;
    typedef logic [`ICACHE_DATA_W-1:0] word_t;

    // field split of a byte address
    typedef struct packed {
        tag_t tag;
        index_t index;
        word_sel_t word;
        logic [BYTE_W-1:0] byte_off;
    } line_addr_t;

endpackage

`default_nettype wire

// ==== icache_bus_pkg.sv ====
`default_nettype none

package icache_bus_pkg;

    import icache_addr_pkg::*;

    // op bit for index invalidate
    localparam int OP_INDEX_INV = 0;

    typedef struct packed {
        logic req;
        line_addr_t addr;
    } cpu_req_t;

    // addr carries the way in bits 13:12 and the set index
    typedef struct packed {
        logic req;
        logic [2:0] op;
        line_addr_t addr;
    } cache_op_t;

    typedef struct packed {
        logic valid;
        line_addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        logic valid;
        word_t data;
        logic last;
    } axi_r_t;

    // one refill write into the arrays
    typedef struct packed {
        logic we;
        way_t way;
        index_t index;
        word_sel_t word;
        word_t data;
        logic tag_we;
        tag_t tag;
    } fill_t;

    typedef struct packed {
        logic we;
        way_t way;
        index_t index;
    } inval_t;

endpackage

`default_nettype wire

// ==== icache_sram.sv ====
`default_nettype none

`include "icache_settings.svh"

module icache_sram
    import icache_addr_pkg::*;
#(
    parameter type entry_t = word_t
)
(
    input logic clk,
    input logic we,
    input index_t index,
    input entry_t wdata,
    output entry_t rdata
);

    entry_t mem [`ICACHE_SETS];

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== icache_ways.sv ====
`default_nettype none

`include "icache_settings.svh"

module icache_ways
    import icache_addr_pkg::*;
    import icache_bus_pkg::*;
(
    input logic clk,
    input logic rst,
    input index_t rd_index,
    input line_addr_t cmp_addr,
    input fill_t fill,
    input inval_t inval,
    output logic hit,
    output way_t hit_way,
    output word_t rdata
);

    index_t arr_index;
    logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0] valid_rd;
    logic [`ICACHE_WAYS-1:0] hit_vec;
    tag_t tag_rd [`ICACHE_WAYS];
    word_t bank_rd [`ICACHE_WAYS][`ICACHE_LINE_WORDS];

    // refill beat owns the array port
    assign arr_index = fill.we ? fill.index : rd_index;

    for (genvar w = 0; w < `ICACHE_WAYS; w++)
    begin : g_way
        icache_sram #(.entry_t(tag_t)) u_tag (
            .clk(clk),
            .we(fill.tag_we && (fill.way == way_t'(w))),
            .index(arr_index),
            .wdata(fill.tag),
            .rdata(tag_rd[w])
        );

        for (genvar b = 0; b < `ICACHE_LINE_WORDS; b++)
        begin : g_bank
            icache_sram #(.entry_t(word_t)) u_data (
                .clk(clk),
                .we(fill.we && (fill.way == way_t'(w)) && (fill.word == word_sel_t'(b))),
                .index(arr_index),
                .wdata(fill.data),
                .rdata(bank_rd[w][b])
            );
        end

        assign hit_vec[w] = valid_rd[w] && (tag_rd[w] == cmp_addr.tag);
    end

    // valid bits, read with the same latency as the arrays
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int w = 0; w < `ICACHE_WAYS; w++)
            begin
                valid_q[w] <= '0;
            end
            valid_rd <= '0;
        end
        else
        begin
            if (fill.tag_we)
            begin
                valid_q[fill.way][fill.index] <= 1'b1;
            end
            if (inval.we)
            begin
                valid_q[inval.way][inval.index] <= 1'b0;
            end
            for (int w = 0; w < `ICACHE_WAYS; w++)
            begin
                valid_rd[w] <= valid_q[w][arr_index];
            end
        end
    end

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
            if (hit_vec[w])
            begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;
    assign rdata = bank_rd[hit_way][cmp_addr.word];

    // a line is never filled into a second way of its set
    assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== icache_lru.sv ====
`default_nettype none

`include "icache_settings.svh"

module icache_lru
    import icache_addr_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic touch,
    input index_t touch_index,
    input way_t touch_way,
    input index_t victim_index,
    output way_t victim_way
);

    // entry 0 is the newest way, the last entry the oldest
    way_t [`ICACHE_WAYS-1:0] order_q [`ICACHE_SETS];
    way_t [`ICACHE_WAYS-1:0] cur_order;
    way_t [`ICACHE_WAYS-1:0] next_order;
    way_t touch_pos;

    function automatic logic is_perm(way_t [`ICACHE_WAYS-1:0] order);
        logic [`ICACHE_WAYS-1:0] seen;
        seen = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++)
        begin
            seen[order[i]] = 1'b1;
        end
        return &seen;
    endfunction

    always_comb
    begin
        cur_order = order_q[touch_index];
        touch_pos = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++)
        begin
            if (cur_order[i] == touch_way)
            begin
                touch_pos = way_t'(i);
            end
        end
        // newer entries slide down one place
        next_order[0] = touch_way;
        for (int i = 1; i < `ICACHE_WAYS; i++)
        begin
            next_order[i] = (way_t'(i) <= touch_pos) ? cur_order[i-1] : cur_order[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `ICACHE_SETS; s++)
            begin
                for (int i = 0; i < `ICACHE_WAYS; i++)
                begin
                    order_q[s][i] <= way_t'(i);
                end
            end
        end
        else if (touch)
        begin
            order_q[touch_index] <= next_order;
        end
    end

    assign victim_way = order_q[victim_index][`ICACHE_WAYS-1];

    assert property (@(posedge clk) disable iff (rst)
        touch |=> is_perm(order_q[$past(touch_index)]));

endmodule

`default_nettype wire

// ==== icache_refill.sv ====
`default_nettype none

`include "icache_settings.svh"

module icache_refill
    import icache_addr_pkg::*;
    import icache_bus_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic start,
    input line_addr_t line_addr,
    input way_t victim_way,
    output axi_ar_t ar,
    input logic ar_ready,
    input axi_r_t r,
    output logic r_ready,
    output fill_t fill,
    output logic done
);

    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} refill_state_t;

    refill_state_t state_q;
    line_addr_t line_q;
    way_t way_q;
    word_sel_t beat_cnt;
    logic beat;

    assign beat = (state_q == R_DATA) && r.valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= R_IDLE;
            beat_cnt <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= beat && r.last;
            case (state_q)
                R_IDLE:
                begin
                    if (start)
                    begin
                        state_q <= R_ADDR;
                        beat_cnt <= '0;
                    end
                end
                R_ADDR:
                begin
                    if (ar_ready)
                    begin
                        state_q <= R_DATA;
                    end
                end
                R_DATA:
                begin
                    if (beat)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last)
                        begin
                            state_q <= R_IDLE;
                        end
                    end
                end
                default:
                begin
                    state_q <= R_IDLE;
                end
            endcase
        end
    end

    // burst starts at word 0 of the line
    always_ff @(posedge clk)
    begin
        if ((state_q == R_IDLE) && start)
        begin
            line_q <= '{tag: line_addr.tag, index: line_addr.index, word: '0, byte_off: '0};
            way_q <= victim_way;
        end
    end

    assign ar.valid = (state_q == R_ADDR);
    assign ar.addr = line_q;
    assign r_ready = (state_q == R_DATA);

    assign fill.we = beat;
    assign fill.way = way_q;
    assign fill.index = line_q.index;
    assign fill.word = beat_cnt;
    assign fill.data = r.data;
    // tag and valid go in with the last beat
    assign fill.tag_we = beat && r.last;
    assign fill.tag = line_q.tag;

    assert property (@(posedge clk) disable iff (rst)
        beat |-> (r.last == (beat_cnt == word_sel_t'(`ICACHE_LINE_WORDS - 1))));

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none

module icache_ctrl
    import icache_addr_pkg::*;
    import icache_bus_pkg::*;
(
    input logic clk,
    input logic rst,
    input cpu_req_t cpu,
    input cache_op_t op,
    output logic addr_ok,
    output logic data_ok,
    output logic op_ok,
    input logic hit,
    input way_t hit_way,
    output index_t rd_index,
    output line_addr_t cmp_addr,
    output logic touch,
    output logic refill_start,
    input logic refill_done,
    output inval_t inval
);

    typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, RELOOKUP, OP} ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    line_addr_t addr_q;
    logic [2:0] op_q;
    logic cpu_take;
    logic op_take;
    logic in_lookup;

    // cpu request beats a pending op
    assign cpu_take = (state_q == IDLE) && cpu.req;
    assign op_take = (state_q == IDLE) && !cpu.req && op.req;
    assign in_lookup = (state_q == LOOKUP) || (state_q == RELOOKUP);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (cpu_take)
                begin
                    state_d = LOOKUP;
                end
                else if (op_take)
                begin
                    state_d = OP;
                end
            end
            LOOKUP, RELOOKUP:
            begin
                state_d = hit ? IDLE : REFILL;
            end
            REFILL:
            begin
                if (refill_done)
                begin
                    state_d = RELOOKUP;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpu_take)
        begin
            addr_q <= cpu.addr;
        end
        else if (op_take)
        begin
            addr_q <= op.addr;
            op_q <= op.op;
        end
    end

    assign addr_ok = cpu_take;
    assign data_ok = in_lookup && hit;
    assign touch = data_ok;
    assign refill_start = in_lookup && !hit;
    assign op_ok = (state_q == OP);

    // arrays read the incoming index while idle
    assign rd_index = (state_q == IDLE) ? cpu.addr.index : addr_q.index;
    assign cmp_addr = addr_q;

    // way number sits in the low tag bits of the op address
    assign inval.we = (state_q == OP) && op_q[OP_INDEX_INV];
    assign inval.way = addr_q.tag[WAY_W-1:0];
    assign inval.index = addr_q.index;

    assert property (@(posedge clk) disable iff (rst)
        data_ok |-> ((state_q == LOOKUP) && $past(addr_ok))
            || ((state_q == RELOOKUP) && $past(refill_done)));

    // the refilled line must be visible on the re-read
    assert property (@(posedge clk) disable iff (rst)
        (state_q == RELOOKUP) |-> (hit && !$isunknown(hit_way)));

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top
    import icache_addr_pkg::*;
    import icache_bus_pkg::*;
(
    input logic clk,
    input logic rst,
    input cpu_req_t cpu,
    input cache_op_t op,
    output logic addr_ok,
    output logic data_ok,
    output word_t rdata,
    output logic op_ok,
    output axi_ar_t ar,
    input logic ar_ready,
    input axi_r_t r,
    output logic r_ready
);

    logic hit;
    way_t hit_way;
    index_t rd_index;
    line_addr_t cmp_addr;
    logic touch;
    logic refill_start;
    logic refill_done;
    way_t victim_way;
    inval_t inval;
    fill_t fill;

    icache_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .cpu(cpu),
        .op(op),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .op_ok(op_ok),
        .hit(hit),
        .hit_way(hit_way),
        .rd_index(rd_index),
        .cmp_addr(cmp_addr),
        .touch(touch),
        .refill_start(refill_start),
        .refill_done(refill_done),
        .inval(inval)
    );

    icache_ways u_ways (
        .clk(clk),
        .rst(rst),
        .rd_index(rd_index),
        .cmp_addr(cmp_addr),
        .fill(fill),
        .inval(inval),
        .hit(hit),
        .hit_way(hit_way),
        .rdata(rdata)
    );

    // lookup address picks both the touched set and the victim set
    icache_lru u_lru (
        .clk(clk),
        .rst(rst),
        .touch(touch),
        .touch_index(cmp_addr.index),
        .touch_way(hit_way),
        .victim_index(cmp_addr.index),
        .victim_way(victim_way)
    );

    icache_refill u_refill (
        .clk(clk),
        .rst(rst),
        .start(refill_start),
        .line_addr(cmp_addr),
        .victim_way(victim_way),
        .ar(ar),
        .ar_ready(ar_ready),
        .r(r),
        .r_ready(r_ready),
        .fill(fill),
        .done(refill_done)
    );

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

`include "icache_settings.svh"

module tb_icache
    import icache_addr_pkg::*;
    import icache_bus_pkg::*;
();

    localparam int CLK_HALF = 20;
    localparam int DRV_DLY = 2;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CMDS = 64;
    localparam int CYCLES_PER_CMD = 40;

    logic clk;
    logic rst;
    cpu_req_t cpu;
    cache_op_t op;
    logic addr_ok;
    logic data_ok;
    word_t rdata;
    logic op_ok;
    axi_ar_t ar;
    logic ar_ready;
    axi_r_t r;
    logic r_ready;

    // cmd, way, addr, expected data, expected hit
    logic [75:0] stim [MAX_CMDS];
    integer seed;
    int cycle_cnt;
    int cycle_limit = 0;
    int fail_cnt;

    // reference state, order entry 0 is the newest way
    logic model_valid [`ICACHE_WAYS][`ICACHE_SETS];
    tag_t model_tag [`ICACHE_WAYS][`ICACHE_SETS];
    way_t model_order [`ICACHE_SETS][`ICACHE_WAYS];

    icache_top u_icache_top (
        .clk(clk),
        .rst(rst),
        .cpu(cpu),
        .op(op),
        .addr_ok(addr_ok),
        .data_ok(data_ok),
        .rdata(rdata),
        .op_ok(op_ok),
        .ar(ar),
        .ar_ready(ar_ready),
        .r(r),
        .r_ready(r_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #CLK_HALF clk = ~clk;
        end
    end

    function automatic word_t mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a5a5a;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (actual !== expected)
        begin
            fail_cnt++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping on error");
    endtask

    task automatic model_reset();
        for (int s = 0; s < `ICACHE_SETS; s++)
        begin
            for (int w = 0; w < `ICACHE_WAYS; w++)
            begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s] = '0;
                model_order[s][w] = way_t'(w);
            end
        end
    endtask

    task automatic model_touch(input index_t s, input way_t w);
        int pos;
        pos = 0;
        for (int i = 0; i < `ICACHE_WAYS; i++)
        begin
            if (model_order[s][i] == w)
            begin
                pos = i;
            end
        end
        for (int i = pos; i > 0; i--)
        begin
            model_order[s][i] = model_order[s][i-1];
        end
        model_order[s][0] = w;
    endtask

    // miss fills the oldest way, both cases make the way newest
    task automatic model_access(input logic [31:0] addr, output logic hit);
        line_addr_t a;
        way_t w;
        a = addr;
        hit = 1'b0;
        w = model_order[a.index][`ICACHE_WAYS-1];
        for (int i = 0; i < `ICACHE_WAYS; i++)
        begin
            if (model_valid[i][a.index] && (model_tag[i][a.index] == a.tag))
            begin
                hit = 1'b1;
                w = way_t'(i);
            end
        end
        if (!hit)
        begin
            model_valid[w][a.index] = 1'b1;
            model_tag[w][a.index] = a.tag;
        end
        model_touch(a.index, w);
    endtask

    task automatic run_access(input int idx, input logic [31:0] addr, input word_t exp_data,
                              input logic exp_hit);
        logic model_hit;
        logic saw_ar;
        logic got_data;
        line_addr_t line;
        model_access(addr, model_hit);
        compare_values($sformatf("cmd %0d model hit", idx), {31'b0, exp_hit}, {31'b0, model_hit});
        compare_values($sformatf("cmd %0d stimulus data", idx), exp_data, mem_word(addr));
        line = addr;
        line.word = '0;
        line.byte_off = '0;
        saw_ar = 1'b0;
        got_data = 1'b0;
        cpu.req = 1'b1;
        cpu.addr = addr;
        @(negedge clk);
        while (!addr_ok)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRV_DLY;
        cpu.req = 1'b0;
        // a miss shows up as ar.valid before data_ok
        while (!got_data)
        begin
            @(negedge clk);
            if (ar.valid && !saw_ar)
            begin
                saw_ar = 1'b1;
                compare_values($sformatf("cmd %0d ar addr", idx), line, ar.addr);
            end
            if (data_ok)
            begin
                got_data = 1'b1;
                compare_values($sformatf("cmd %0d rdata", idx), exp_data, rdata);
            end
            @(posedge clk);
            #DRV_DLY;
        end
        compare_values($sformatf("cmd %0d hit", idx), {31'b0, exp_hit}, {31'b0, !saw_ar});
    endtask

    task automatic run_invalidate(input int idx, input way_t way, input logic [31:0] addr);
        line_addr_t a;
        int pulses;
        a = addr;
        model_valid[way][a.index] = 1'b0;
        // way goes into address bits 13:12
        a.tag = tag_t'(way);
        a.word = '0;
        a.byte_off = '0;
        pulses = 0;
        op.req = 1'b1;
        op.op = 3'b001;
        op.addr = a;
        @(posedge clk);
        #DRV_DLY;
        op.req = 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            if (op_ok)
            begin
                pulses++;
            end
            @(posedge clk);
            #DRV_DLY;
        end
        compare_values($sformatf("cmd %0d op_ok pulses", idx), 32'd1, pulses);
    endtask

    // memory side of the read burst, with random stalls
    initial
    begin : axi_mem
        logic [31:0] base;
        int stall;
        seed = 32'h38c6676b;
        ar_ready = 1'b0;
        r = '0;
        forever
        begin
            @(negedge clk);
            if (!rst && ar.valid)
            begin
                stall = $random(seed) & 3;
                @(posedge clk);
                #DRV_DLY;
                repeat (stall)
                begin
                    @(posedge clk);
                    #DRV_DLY;
                end
                ar_ready = 1'b1;
                base = ar.addr;
                @(posedge clk);
                #DRV_DLY;
                ar_ready = 1'b0;
                for (int b = 0; b < `ICACHE_LINE_WORDS; b++)
                begin
                    stall = $random(seed) & 1;
                    repeat (stall)
                    begin
                        @(posedge clk);
                        #DRV_DLY;
                    end
                    r.valid = 1'b1;
                    r.data = mem_word(base + 32'(b * 4));
                    r.last = (b == `ICACHE_LINE_WORDS - 1);
                    @(negedge clk);
                    compare_values("r_ready during beat", 32'd1, {31'b0, r_ready});
                    @(posedge clk);
                    #DRV_DLY;
                    r.valid = 1'b0;
                    r.last = 1'b0;
                end
            end
        end
    end

    initial
    begin : watchdog
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        stop_with_error($sformatf("Timeout: run did not finish in %0d cycles", cycle_limit));
    end

    initial
    begin : main_seq
        int n_cmds;
        logic [75:0] e;
        rst = 1'b1;
        cpu = '0;
        op = '0;
        fail_cnt = 0;
        for (int i = 0; i < MAX_CMDS; i++)
        begin
            stim[i] = '0;
        end
        $readmemh("icache_stimulus.txt", stim);
        n_cmds = 0;
        while ((n_cmds < MAX_CMDS) && (stim[n_cmds][75:72] != 4'h0))
        begin
            n_cmds++;
        end
        if (n_cmds == 0)
        begin
            stop_with_error("No commands found in icache_stimulus.txt");
        end
        cycle_limit = n_cmds * CYCLES_PER_CMD + RESET_CYCLES;
        model_reset();
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
        end
        #DRV_DLY;
        rst = 1'b0;
        for (int i = 0; i < n_cmds; i++)
        begin
            e = stim[i];
            case (e[75:72])
                4'h1:
                begin
                    run_access(i, e[67:36], e[35:4], e[0]);
                end
                4'h2:
                begin
                    run_invalidate(i, e[69:68], e[67:36]);
                end
                default:
                begin
                    stop_with_error($sformatf("Unknown command code in stimulus line %0d", i));
                end
            endcase
        end
        if (fail_cnt == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_stimulus.txt ====
// columns: cmd (1 access, 2 index invalidate), way, address, expected data, expected hit
// invalidate takes the set from the address column and ignores data and hit
// set 0x10, first fills and hits
1_0_00001204_5a5a485e_0
1_0_0000121c_5a5a4846_1
1_0_00001200_5a5a485a_1
1_0_00002208_5a5a7852_0
1_0_00003210_5a5a684a_0
1_0_00004214_5a5a184e_0
// fifth tag evicts the oldest way
1_0_00005200_5a5a085a_0
1_0_00002200_5a5a785a_1
1_0_00003218_5a5a6842_1
1_0_0000420c_5a5a1856_1
1_0_00005204_5a5a085e_1
1_0_00001210_5a5a484a_0
// hit on the oldest way moves the victim
1_0_00003204_5a5a685e_1
1_0_00002200_5a5a785a_0
1_0_00003200_5a5a685a_1
1_0_00004200_5a5a185a_0
// invalidate way 1 of set 0x10
2_1_00000200_00000000_0
1_0_00003208_5a5a6852_0
1_0_00002214_5a5a784e_1
1_0_0000421c_5a5a1846_1
1_0_00001218_5a5a4842_0
// set 0x33
1_0_12345678_486e0c22_0
1_0_12345660_486e0c3a_1
2_3_00000660_00000000_0
1_0_1234567c_486e0c26_0
2_0_00000200_00000000_0
1_0_00002204_5a5a785e_0
1_0_00004218_5a5a1842_1
1_0_0000120c_5a5a4856_1
// top of the address range, set 0x7f
1_0_fffffffc_a5a5a5a6_0
1_0_ffffffe0_a5a5a5ba_1

// ==== compile.f ====
+incdir+.
icache_addr_pkg.sv
icache_bus_pkg.sv
icache_sram.sv
icache_ways.sv
icache_lru.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_icache -Mdir obj_dir \
    && ./obj_dir/Vtb_icache 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"
